// ==== source/dds_pkg.sv ====
`default_nettype none

package dds_pkg;

   ///////////////////////////////////////////////////////////////////////
   // widths

   localparam int unsigned phase_w    = 32;   // phase accumulator
   localparam int unsigned sample_w   = 12;   // signed carrier sample
   localparam int unsigned rom_addr_w = 5;    // quarter-wave rom index
   localparam int unsigned lfsr_w     = 5;
   localparam int unsigned apb_addr_w = 4;
   localparam int unsigned apb_data_w = 32;

   localparam logic [lfsr_w-1:0] lfsr_seed = 'd1;

   // register map, byte addresses
   localparam logic [apb_addr_w-1:0] addr_ctrl     = 'h0;
   localparam logic [apb_addr_w-1:0] addr_base_inc = 'h4;
   localparam logic [apb_addr_w-1:0] addr_fsk_inc  = 'h8;
   localparam logic [apb_addr_w-1:0] addr_period   = 'hC;

   localparam logic [phase_w-1:0] rst_base_inc = 'd258;
   localparam logic [phase_w-1:0] rst_fsk_inc  = 'd1024;
   localparam logic [phase_w-1:0] rst_period   = 'd16;   // clock cycles per symbol

   // carrier select
   localparam logic [1:0] car_sin = 2'd0;
   localparam logic [1:0] car_cos = 2'd1;
   localparam logic [1:0] car_saw = 2'd2;
   localparam logic [1:0] car_squ = 2'd3;

   // modulation select
   localparam logic [1:0] mod_ask  = 2'd0;
   localparam logic [1:0] mod_fsk  = 2'd1;
   localparam logic [1:0] mod_bpsk = 2'd2;
   localparam logic [1:0] mod_raw  = 2'd3;

   localparam logic signed [sample_w-1:0] sample_max = {1'b0, {(sample_w-1){1'b1}}};
   localparam logic signed [sample_w-1:0] sample_min = {1'b1, {(sample_w-1){1'b0}}};

   // one sample word, as a number or split for the scope byte
   typedef union packed {
      logic signed [sample_w-1:0] value;
      struct packed {
         logic       sign;
         logic [6:0] mag_hi;   // top byte after the sign
         logic [3:0] lsb;
      } field;
   } sample_u;

endpackage

`default_nettype wire

// ==== source/apb_control_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_control_regs (
   input  wire logic                            CLK_25MHZ,
   input  wire logic                            reset_from_key,
   input  wire logic [dds_pkg::apb_addr_w-1:0]  paddr,
   input  wire logic                            psel,
   input  wire logic                            penable,
   input  wire logic                            pwrite,
   input  wire logic [dds_pkg::apb_data_w-1:0]  pwdata,
   input  wire logic                            data_bit,
   output logic      [dds_pkg::apb_data_w-1:0]  prdata,
   output logic                                 pready,
   output logic                                 pslverr,
   output logic      [1:0]                      carrier_sel,
   output logic      [1:0]                      mod_sel,
   output logic      [dds_pkg::phase_w-1:0]     base_inc,
   output logic      [dds_pkg::phase_w-1:0]     fsk_inc,
   output logic      [dds_pkg::phase_w-1:0]     symbol_period
);

   logic mapped;
   logic access;

   assign access = psel && penable;
   assign pready = 1'b1;   // zero wait states
   assign pslverr = access && !mapped;

   ///////////////////////////////////////////////////////////////////////
   // address decode and readback

   always_comb
   begin
      mapped = 1'b1;
      prdata = '0;
      case (paddr)
         dds_pkg::addr_ctrl:
            prdata = {23'd0, data_bit, 4'd0, mod_sel, carrier_sel};   // live symbol in bit 8
         dds_pkg::addr_base_inc: prdata = base_inc;
         dds_pkg::addr_fsk_inc:  prdata = fsk_inc;
         dds_pkg::addr_period:   prdata = symbol_period;
         default:                mapped = 1'b0;   // reads back zero
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // register writes, end of access cycle

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         carrier_sel   <= dds_pkg::car_sin;
         mod_sel       <= dds_pkg::mod_ask;
         base_inc      <= dds_pkg::rst_base_inc;
         fsk_inc       <= dds_pkg::rst_fsk_inc;
         symbol_period <= dds_pkg::rst_period;
      end
      else if (access && pwrite)
      begin
         case (paddr)
            dds_pkg::addr_ctrl:
            begin
               carrier_sel <= pwdata[1:0];
               mod_sel     <= pwdata[3:2];
            end
            dds_pkg::addr_base_inc: base_inc      <= pwdata;
            dds_pkg::addr_fsk_inc:  fsk_inc       <= pwdata;
            dds_pkg::addr_period:   symbol_period <= pwdata;
            default: ;   // unmapped, ignored
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/symbol_source.sv ====
`timescale 1ns/1ns
`default_nettype none

module symbol_source (
   input  wire logic                        CLK_25MHZ,
   input  wire logic                        reset_from_key,
   input  wire logic [dds_pkg::phase_w-1:0] symbol_period,
   output logic                             data_bit
);

   logic [dds_pkg::phase_w-1:0] count;
   logic [dds_pkg::phase_w-1:0] last_count;
   logic [dds_pkg::lfsr_w-1:0]  lfsr;
   logic                        wrap;

   // period of zero behaves as one
   assign last_count = (symbol_period == '0) ? '0 : symbol_period - 1'b1;

   // >= also catches a period shortened below the running count
   assign wrap = (count >= last_count);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         count <= '0;
      end
      else if (wrap)
      begin
         count <= '0;
      end
      else
      begin
         count <= count + 1'b1;
      end
   end

   // x^5 + x^3 + 1, shifting right
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr <= dds_pkg::lfsr_seed;
      else if (wrap)
         lfsr <= {lfsr[0] ^ lfsr[2], lfsr[4:1]};   // one step per symbol
   end

   assign data_bit = lfsr[0];

endmodule

`default_nettype wire

// ==== source/phase_wave_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_wave_gen (
   input  wire logic                                CLK_25MHZ,
   input  wire logic                                reset_from_key,
   input  wire logic        [dds_pkg::phase_w-1:0]  phase_inc,
   output logic signed      [dds_pkg::sample_w-1:0] sin_sample,
   output logic signed      [dds_pkg::sample_w-1:0] cos_sample,
   output logic signed      [dds_pkg::sample_w-1:0] saw_sample,
   output logic signed      [dds_pkg::sample_w-1:0] squ_sample
);

   localparam int unsigned rom_depth = 2 ** dds_pkg::rom_addr_w;

   logic signed [dds_pkg::sample_w-1:0] sine_rom [0:rom_depth-1];   // first quadrant only

   logic [dds_pkg::phase_w-1:0]    phase;
   logic [1:0]                     quad;
   logic [dds_pkg::rom_addr_w-1:0] idx;

   initial
   begin
      $readmemh("sine_quarter.hex", sine_rom);
   end

   // mirror index in odd quadrants, negate in the lower half
   function automatic logic signed [dds_pkg::sample_w-1:0] quarter_lookup(
      input logic [1:0]                     q,
      input logic [dds_pkg::rom_addr_w-1:0] i
   );
      logic [dds_pkg::rom_addr_w-1:0]      addr;
      logic signed [dds_pkg::sample_w-1:0] mag;
      addr = q[0] ? ~i : i;
      mag  = sine_rom[addr];
      return q[1] ? -mag : mag;
   endfunction

   assign quad = phase[dds_pkg::phase_w-1 -: 2];
   assign idx  = phase[dds_pkg::phase_w-3 -: dds_pkg::rom_addr_w];

   ///////////////////////////////////////////////////////////////////////
   // accumulator and registered shapes

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase      <= '0;
         sin_sample <= '0;
         cos_sample <= '0;
         saw_sample <= '0;
         squ_sample <= '0;
      end
      else
      begin
         phase      <= phase + phase_inc;
         sin_sample <= quarter_lookup(quad, idx);
         cos_sample <= quarter_lookup(quad + 2'd1, idx);   // a quarter turn ahead
         saw_sample <= $signed(phase[dds_pkg::phase_w-1 -: dds_pkg::sample_w]);
         squ_sample <= phase[dds_pkg::phase_w-1] ? dds_pkg::sample_min : dds_pkg::sample_max;
      end
   end

endmodule

`default_nettype wire

// ==== source/modulator.sv ====
`timescale 1ns/1ns
`default_nettype none

module modulator (
   input  wire logic                                CLK_25MHZ,
   input  wire logic                                reset_from_key,
   input  wire logic        [1:0]                   carrier_sel,
   input  wire logic        [1:0]                   mod_sel,
   input  wire logic        [dds_pkg::phase_w-1:0]  base_inc,
   input  wire logic        [dds_pkg::phase_w-1:0]  fsk_inc,
   input  wire logic                                data_bit,
   input  wire logic signed [dds_pkg::sample_w-1:0] sin_sample,
   input  wire logic signed [dds_pkg::sample_w-1:0] cos_sample,
   input  wire logic signed [dds_pkg::sample_w-1:0] saw_sample,
   input  wire logic signed [dds_pkg::sample_w-1:0] squ_sample,
   output logic             [dds_pkg::phase_w-1:0]  phase_inc,
   output logic signed      [dds_pkg::sample_w-1:0] carrier_sample,
   output logic signed      [dds_pkg::sample_w-1:0] modulated_sample,
   output logic             [7:0]                   scope_byte
);

   logic signed [dds_pkg::sample_w-1:0] carrier;
   dds_pkg::sample_u                    mod_next;

   // second increment only while keying a one
   assign phase_inc = (mod_sel == dds_pkg::mod_fsk && data_bit) ? fsk_inc : base_inc;

   always_comb
   begin
      case (carrier_sel)
         dds_pkg::car_sin: carrier = sin_sample;
         dds_pkg::car_cos: carrier = cos_sample;
         dds_pkg::car_saw: carrier = saw_sample;
         default:          carrier = squ_sample;
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // keying

   always_comb
   begin
      case (mod_sel)
         dds_pkg::mod_ask:
            mod_next.value = data_bit ? carrier : '0;
         dds_pkg::mod_fsk:
            mod_next.value = carrier;   // keying is in the increment
         dds_pkg::mod_bpsk:
         begin
            if (data_bit)
               mod_next.value = carrier;
            else if (carrier == dds_pkg::sample_min)
               mod_next.value = dds_pkg::sample_max;   // no +2048 in 12 bits
            else
               mod_next.value = -carrier;
         end
         default:
            mod_next.value = data_bit ? dds_pkg::sample_max : dds_pkg::sample_min;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         carrier_sample   <= '0;
         modulated_sample <= '0;
         scope_byte       <= '0;
      end
      else
      begin
         carrier_sample   <= carrier;
         modulated_sample <= mod_next.value;
         scope_byte       <= {~mod_next.field.sign, mod_next.field.mag_hi};   // offset binary
      end
   end

endmodule

`default_nettype wire

// ==== source/dds_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dds_top (
   input  wire logic                                CLK_25MHZ,
   input  wire logic                                reset_from_key,
   input  wire logic        [dds_pkg::apb_addr_w-1:0] paddr,
   input  wire logic                                psel,
   input  wire logic                                penable,
   input  wire logic                                pwrite,
   input  wire logic        [dds_pkg::apb_data_w-1:0] pwdata,
   output logic             [dds_pkg::apb_data_w-1:0] prdata,
   output logic                                     pready,
   output logic                                     pslverr,
   output logic signed      [dds_pkg::sample_w-1:0]   carrier_sample,
   output logic signed      [dds_pkg::sample_w-1:0]   modulated_sample,
   output logic             [7:0]                     scope_byte,
   output logic                                     data_bit
);

   logic [1:0]                          carrier_sel;
   logic [1:0]                          mod_sel;
   logic [dds_pkg::phase_w-1:0]         base_inc;
   logic [dds_pkg::phase_w-1:0]         fsk_inc;
   logic [dds_pkg::phase_w-1:0]         symbol_period;
   logic [dds_pkg::phase_w-1:0]         phase_inc;
   logic signed [dds_pkg::sample_w-1:0] sin_sample;
   logic signed [dds_pkg::sample_w-1:0] cos_sample;
   logic signed [dds_pkg::sample_w-1:0] saw_sample;
   logic signed [dds_pkg::sample_w-1:0] squ_sample;

   apb_control_regs u_apb_control_regs (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .paddr          (paddr),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .pwdata         (pwdata),
      .data_bit       (data_bit),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .carrier_sel    (carrier_sel),
      .mod_sel        (mod_sel),
      .base_inc       (base_inc),
      .fsk_inc        (fsk_inc),
      .symbol_period  (symbol_period)
   );

   symbol_source u_symbol_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .symbol_period  (symbol_period),
      .data_bit       (data_bit)
   );

   phase_wave_gen u_phase_wave_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .sin_sample     (sin_sample),
      .cos_sample     (cos_sample),
      .saw_sample     (saw_sample),
      .squ_sample     (squ_sample)
   );

   modulator u_modulator (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .carrier_sel      (carrier_sel),
      .mod_sel          (mod_sel),
      .base_inc         (base_inc),
      .fsk_inc          (fsk_inc),
      .data_bit         (data_bit),
      .sin_sample       (sin_sample),
      .cos_sample       (cos_sample),
      .saw_sample       (saw_sample),
      .squ_sample       (squ_sample),
      .phase_inc        (phase_inc),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample),
      .scope_byte       (scope_byte)
   );

endmodule

`default_nettype wire

// ==== test/dds_top_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module dds_top_asserts (
   input wire logic                           CLK_25MHZ,
   input wire logic                           reset_from_key,
   input wire logic [dds_pkg::apb_addr_w-1:0] paddr,
   input wire logic                           psel,
   input wire logic                           penable,
   input wire logic                           pslverr,
   input wire logic                           data_bit,
   input wire logic [dds_pkg::phase_w-1:0]    symbol_period
);

   logic [dds_pkg::phase_w-1:0] ticks;   // shadow of the symbol counter
   logic                        tick_wrap;

   assign tick_wrap = ticks >= ((symbol_period == '0) ? '0 : symbol_period - 32'd1);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || tick_wrap)
         ticks <= '0;
      else
         ticks <= ticks + 32'd1;
   end

   ///////////////////////////////////////////////////////////////////////
   // apb and symbol properties

   // error only in an access cycle to an address off the word grid
   pslverr_unmapped_access: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      pslverr == (psel && penable && paddr[1:0] != 2'b00))
      else $error("pslverr does not match an access cycle to an unmapped address");

   // symbol may only move on the edge after a wrap
   data_bit_on_wrap: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !tick_wrap |=> $stable(data_bit))
      else $error("data_bit changed without a counter wrap");

endmodule

bind apb_control_regs dds_top_asserts u_dds_top_asserts (
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .paddr          (paddr),
   .psel           (psel),
   .penable        (penable),
   .pslverr        (pslverr),
   .data_bit       (data_bit),
   .symbol_period  (symbol_period)
);

`default_nettype wire

// ==== test/tb_dds_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dds_top;

   localparam int clk_period = 40;
   localparam int run_len    = 160;   // cycles per stream run
   localparam int n_runs     = 20;
   localparam int run_setup  = 12;    // register writes ahead of a run
   localparam int n_mid      = 30;    // mid-stream writes
   localparam int mid_cycles = 9;
   localparam int margin     = 300;
   localparam int timeout_ns =
      (n_runs * (run_len + run_setup) + n_mid * mid_cycles + margin) * clk_period;

   localparam logic signed [11:0] full_pos = 12'sh7FF;
   localparam logic signed [11:0] full_neg = 12'sh800;

   logic                                CLK_25MHZ;
   logic                                reset_from_key;
   logic [dds_pkg::apb_addr_w-1:0]      paddr;
   logic                                psel;
   logic                                penable;
   logic                                pwrite;
   logic [dds_pkg::apb_data_w-1:0]      pwdata;
   logic [dds_pkg::apb_data_w-1:0]      prdata;
   logic                                pready;
   logic                                pslverr;
   logic signed [dds_pkg::sample_w-1:0] carrier_sample;
   logic signed [dds_pkg::sample_w-1:0] modulated_sample;
   logic [7:0]                          scope_byte;
   logic                                data_bit;
   integer                              seed;

   // reference model state, one step per clock
   logic signed [11:0] sine_table [0:31];
   logic               model_valid = 1'b0;
   logic [1:0]         m_car;
   logic [1:0]         m_mod;
   logic [31:0]        m_base;
   logic [31:0]        m_fsk;
   logic [31:0]        m_period;
   logic [31:0]        m_count;
   logic [31:0]        m_phase;
   logic [4:0]         m_lfsr;
   logic signed [11:0] m_sin;
   logic signed [11:0] m_cos;
   logic signed [11:0] m_saw;
   logic signed [11:0] m_squ;
   logic signed [11:0] m_carrier_out;
   logic signed [11:0] m_mod_out;
   logic [7:0]         m_scope;

   dds_top u_dds_top (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .paddr            (paddr),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pready           (pready),
      .pslverr          (pslverr),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample),
      .scope_byte       (scope_byte),
      .data_bit         (data_bit)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #(clk_period / 2) CLK_25MHZ = ~CLK_25MHZ;
   end

   initial
   begin
      $readmemh("sine_quarter.hex", sine_table);
   end

   initial
   begin
      #(timeout_ns);
      $display("timeout: the stream tests ran past the watchdog limit");
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model

   // quadrant 1 and 3 walk the table backwards, lower half is negative
   function automatic logic signed [11:0] sine_of(input logic [31:0] ph);
      logic [1:0]         quadrant;
      logic [4:0]         index;
      logic signed [11:0] mag;
      quadrant = ph[31:30];
      index    = ph[29:25];
      if (quadrant[0])
         index = 5'd31 - index;
      mag = sine_table[index];
      return (quadrant >= 2'd2) ? -mag : mag;
   endfunction

   // offset binary, top byte
   function automatic logic [7:0] scope_of(input logic signed [11:0] v);
      logic [11:0] offset;
      offset = v + 12'h800;
      return offset[11:4];
   endfunction

   function automatic logic is_mapped(input logic [3:0] addr);
      return addr[1:0] == 2'b00;   // every word in the map is a register
   endfunction

   function automatic logic [31:0] expected_rdata(input logic [3:0] addr);
      case (addr)
         4'h0:    return {23'd0, m_lfsr[0], 4'd0, m_mod, m_car};
         4'h4:    return m_base;
         4'h8:    return m_fsk;
         4'hC:    return m_period;
         default: return 32'd0;
      endcase
   endfunction

   task automatic step_model;
      logic [31:0]        inc;
      logic signed [11:0] car;
      logic signed [11:0] keyed;
      logic [31:0]        last;
      if (reset_from_key)
      begin
         m_car    = 2'd0;
         m_mod    = 2'd0;
         m_base   = 32'd258;
         m_fsk    = 32'd1024;
         m_period = 32'd16;
         m_count  = 32'd0;
         m_phase  = 32'd0;
         m_lfsr   = 5'd1;
         m_sin    = 12'sd0;
         m_cos    = 12'sd0;
         m_saw    = 12'sd0;
         m_squ    = 12'sd0;
         m_carrier_out = 12'sd0;
         m_mod_out     = 12'sd0;
         m_scope       = 8'd0;
         model_valid   = 1'b1;
      end
      else if (model_valid)
      begin
         inc = (m_mod == 2'd1 && m_lfsr[0]) ? m_fsk : m_base;
         case (m_car)
            2'd0:    car = m_sin;
            2'd1:    car = m_cos;
            2'd2:    car = m_saw;
            default: car = m_squ;
         endcase
         case (m_mod)
            2'd0:    keyed = m_lfsr[0] ? car : 12'sd0;
            2'd1:    keyed = car;
            2'd2:    keyed = m_lfsr[0] ? car : ((car == full_neg) ? full_pos : -car);
            default: keyed = m_lfsr[0] ? full_pos : full_neg;
         endcase
         m_carrier_out = car;
         m_mod_out     = keyed;
         m_scope       = scope_of(keyed);
         m_sin = sine_of(m_phase);
         m_cos = sine_of(m_phase + 32'h4000_0000);   // quarter turn on
         m_saw = m_phase[31:20];
         m_squ = m_phase[31] ? full_neg : full_pos;
         m_phase = m_phase + inc;
         last = (m_period == 32'd0) ? 32'd0 : m_period - 32'd1;
         if (m_count >= last)
         begin
            m_count = 32'd0;
            m_lfsr  = {m_lfsr[0] ^ m_lfsr[2], m_lfsr[4:1]};
         end
         else
            m_count = m_count + 32'd1;
         if (psel && penable && pwrite)
         begin
            case (paddr)
               4'h0:
               begin
                  m_car = pwdata[1:0];
                  m_mod = pwdata[3:2];
               end
               4'h4: m_base   = pwdata;
               4'h8: m_fsk    = pwdata;
               4'hC: m_period = pwdata;
               default: ;
            endcase
         end
      end
   endtask

   task automatic compare_outputs;
      logic access;
      access = psel && penable;
      check_value("carrier_sample", carrier_sample, m_carrier_out);
      check_value("modulated_sample", modulated_sample, m_mod_out);
      check_value("scope_byte", scope_byte, m_scope);
      check_value("data_bit", data_bit, m_lfsr[0]);
      check_value("pready", pready, 1'b1);
      check_value("pslverr", pslverr, access && !is_mapped(paddr));
      if (access && !pwrite)
         check_value("prdata", prdata, expected_rdata(paddr));
   endtask

   // outputs are settled at the falling edge, inputs held for the next rise
   always @(negedge CLK_25MHZ)
   begin
      if (model_valid)
         compare_outputs();
      step_model();
   end

   //////////////////////////////////////////////////////////////////////
   // apb transfers

   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
      @(posedge CLK_25MHZ);
      paddr   <= addr;
      pwrite  <= 1'b1;
      pwdata  <= data;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge CLK_25MHZ);
      penable <= 1'b1;
      @(negedge CLK_25MHZ);
      while (!pready)
         @(negedge CLK_25MHZ);
      @(posedge CLK_25MHZ);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge CLK_25MHZ);
      paddr   <= addr;
      pwrite  <= 1'b0;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge CLK_25MHZ);
      penable <= 1'b1;
      @(negedge CLK_25MHZ);
      while (!pready)
         @(negedge CLK_25MHZ);
      data = prdata;   // access cycle
      err  = pslverr;
      @(posedge CLK_25MHZ);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic run_cycles(input int n);
      repeat (n) @(posedge CLK_25MHZ);
   endtask

   function automatic logic [31:0] ctrl_word(input logic [1:0] mode, input logic [1:0] car);
      return {28'd0, mode, car};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // test sequence

   initial
   begin
      int          a;
      int          c;
      int          m;
      logic [1:0]  mode_code;
      logic [31:0] data;
      logic        err;
      logic [31:0] rnd;
      seed           = 46;
      reset_from_key = 1'b1;
      paddr          = '0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      pwdata         = '0;
      repeat (4) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;

      // reset values, and an unmapped write that must change nothing
      write_reg(4'h6, $random(seed));
      for (a = 0; a < 16; a++)
      begin
         read_reg(a[3:0], data, err);
         if (a % 4 != 0)
         begin
            check_value("pslverr", err, 1'b1);
            check_value("prdata", data, 32'd0);
         end
         else
         begin
            check_value("pslverr", err, 1'b0);
            case (a)
               0:       check_value("prdata", data & 32'hFFFF_FEFF, 32'd0);
               4:       check_value("prdata", data, 32'd258);
               8:       check_value("prdata", data, 32'd1024);
               default: check_value("prdata", data, 32'd16);
            endcase
         end
      end

      for (c = 0; c < 4; c++)   // carrier shapes
      begin
         write_reg(dds_pkg::addr_ctrl, ctrl_word(dds_pkg::mod_ask, c[1:0]));
         write_reg(dds_pkg::addr_base_inc, $random(seed));
         run_cycles(run_len);
      end

      // symbol sequence, random period then zero
      write_reg(dds_pkg::addr_ctrl, ctrl_word(dds_pkg::mod_ask, dds_pkg::car_sin));
      rnd = $random(seed);
      write_reg(dds_pkg::addr_period, rnd % 20 + 1);
      run_cycles(run_len);
      write_reg(dds_pkg::addr_period, 32'd0);
      run_cycles(40);

      for (m = 0; m < 3; m++)
      begin
         case (m)
            0:       mode_code = dds_pkg::mod_ask;
            1:       mode_code = dds_pkg::mod_bpsk;
            default: mode_code = dds_pkg::mod_raw;
         endcase
         for (c = 0; c < 4; c++)
         begin
            write_reg(dds_pkg::addr_ctrl, ctrl_word(mode_code, c[1:0]));
            write_reg(dds_pkg::addr_base_inc, $random(seed));
            rnd = $random(seed);
            write_reg(dds_pkg::addr_period, rnd % 20 + 1);
            run_cycles(run_len);
         end
      end

      // fsk over several symbols
      write_reg(dds_pkg::addr_ctrl, ctrl_word(dds_pkg::mod_fsk, dds_pkg::car_sin));
      write_reg(dds_pkg::addr_base_inc, $random(seed));
      write_reg(dds_pkg::addr_fsk_inc, $random(seed));
      rnd = $random(seed);
      write_reg(dds_pkg::addr_period, rnd % 20 + 1);
      run_cycles(2 * run_len);

      repeat (n_mid)   // writes into the running stream
      begin
         rnd = $random(seed);
         case (rnd % 4)
            0:       write_reg(dds_pkg::addr_ctrl, rnd[11:8]);
            1:       write_reg(dds_pkg::addr_base_inc, $random(seed));
            2:       write_reg(dds_pkg::addr_fsk_inc, $random(seed));
            default: write_reg(dds_pkg::addr_period, rnd[15:8] % 20 + 1);
         endcase
         rnd = $random(seed);
         run_cycles(rnd % 6);
      end

      run_cycles(4);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dds_lab.f ====
source/dds_pkg.sv
source/apb_control_regs.sv
source/symbol_source.sv
source/phase_wave_gen.sv
source/modulator.sv
source/dds_top.sv
test/dds_top_asserts.sv
test/tb_dds_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_dds_top
FILELIST  = dds_lab.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_LOG   = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) sine_quarter.hex
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -qx "RESULT: PASS" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== sine_quarter.hex ====
// one column: 12-bit signed sine sample, rom index 0 to 31 of the first quadrant
000
064
0C9
12C
18F
1F1
252
2B2
30F
36B
3C5
41C
471
4C3
513
55F
5A7
5ED
62E
66C
6A6
6DC
70D
73A
763
787
7A7
7C2
7D8
7E9
7F5
7FD
